/* logic/pte_format_pkg.sv */
package pte_format_pkg;

    localparam int vaddr_width       = 32;
    localparam int paddr_width       = 34;
    localparam int page_offset_width = 12;
    localparam int vpn_width         = 10;
    localparam int ppn0_width        = 10;
    localparam int ppn1_width        = 12;
    localparam int pte_width         = 32;

    // bit 0 of the PTE is v, bit 7 is d
    typedef struct packed {
        logic d;
        logic a;
        logic g;
        logic u;
        logic x;
        logic w;
        logic r;
        logic v;
    } pte_flags_t;

    // leaf view, megapages take ppn1 alone
    typedef struct packed {
        logic [ppn1_width-1:0] ppn1;
        logic [ppn0_width-1:0] ppn0;
        logic [1:0]            rsw;
        pte_flags_t            flags;
    } pte_leaf_t;

    // pointer view, ppn names the next table page
    typedef struct packed {
        logic [ppn1_width+ppn0_width-1:0] ppn;
        logic [1:0]                       rsw;
        pte_flags_t                       flags;
    } pte_ptr_t;

    typedef union packed {
        pte_leaf_t leaf;
        pte_ptr_t  ptr;
    } pte_t;

endpackage

/* logic/tlb_access_pkg.sv */
package tlb_access_pkg;

    // kind of access behind a lookup
    typedef enum logic [1:0] {
        source_fetch = 2'b00,
        source_load  = 2'b01,
        source_store = 2'b10
    } access_source_t;

    // hypervisor encoding 10 is not supported
    typedef enum logic [1:0] {
        mode_user       = 2'b00,
        mode_supervisor = 2'b01,
        mode_machine    = 2'b11
    } priv_mode_t;

endpackage

/* logic/tlb_page_ram.sv */
module tlb_page_ram #(
    parameter int TAG_WIDTH = 14,
    parameter int DEPTH     = 16,
    parameter int BANK      = 4
) (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic                                            en,
    input  logic                                            we,
    input  logic [$clog2(DEPTH)-1:0]                        idx,
    input  logic [TAG_WIDTH-1:0]                            wtag,
    input  logic [BANK-1:0][pte_format_pkg::pte_width-1:0]  wdata,
    output logic                                            tag_valid,
    output logic [TAG_WIDTH-1:0]                            tag,
    output logic [BANK-1:0][pte_format_pkg::pte_width-1:0]  rdata,
    output logic                                            sweep_busy
);

    localparam int idx_width = $clog2(DEPTH);

    logic                                           valid_mem [DEPTH];
    logic [TAG_WIDTH-1:0]                           tag_mem   [DEPTH];
    logic [BANK-1:0][pte_format_pkg::pte_width-1:0] line_mem  [DEPTH];

    logic [idx_width-1:0] sweep_idx;

    // walk every line once after reset to clear its valid bit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sweep_busy <= 1'b1;
            sweep_idx  <= '0;
        end else if (sweep_busy) begin
            sweep_idx <= sweep_idx + 1'b1;
            if (sweep_idx == idx_width'(DEPTH - 1)) begin
                sweep_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sweep_busy) begin
            valid_mem[sweep_idx] <= 1'b0;
        end else if (we) begin
            valid_mem[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            tag_mem[idx]  <= wtag;
            line_mem[idx] <= wdata;
        end
    end

    // registered read, output holds while en is low
    always_ff @(posedge clk) begin
        if (en) begin
            tag_valid <= valid_mem[idx];
            tag       <= tag_mem[idx];
            rdata     <= line_mem[idx];
        end
    end

    // single port, a refill never shares a cycle with a lookup
    a_no_read_write: assert property (
        @(posedge clk) disable iff (!rst_n) !(we && en)
    );

endmodule

/* logic/tlb_page_level.sv */
module tlb_page_level #(
    parameter int LEVEL = 0,
    parameter int BANK  = 4,
    parameter int DEPTH = 16
) (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic                                            req,
    input  logic                                            flush,
    input  logic [pte_format_pkg::vaddr_width-1:0]          vaddr,
    input  logic                                            refill_we,
    input  logic [pte_format_pkg::vaddr_width-1:0]          refill_vaddr,
    input  logic [BANK-1:0][pte_format_pkg::pte_width-1:0]  refill_data,
    output logic                                            hit,
    output pte_format_pkg::pte_t                            entry,
    output logic                                            sweep_busy
);

    // vpn of this level splits into bank offset, line index and tag
    localparam int vpn_base   = pte_format_pkg::page_offset_width
                              + LEVEL * pte_format_pkg::vpn_width;
    localparam int bank_width = $clog2(BANK);
    localparam int idx_width  = $clog2(DEPTH);
    localparam int tag_base   = vpn_base + bank_width + idx_width;
    localparam int tag_width  = pte_format_pkg::vaddr_width - tag_base;

    logic [pte_format_pkg::vaddr_width-1:0]          ram_addr;
    logic [idx_width-1:0]                            ram_idx;
    logic [tag_width-1:0]                            ram_tag;
    logic                                            ram_tag_valid;
    logic [BANK-1:0][pte_format_pkg::pte_width-1:0]  ram_line;

    logic [tag_width-1:0]  req_tag;
    logic [bank_width-1:0] req_offset;
    logic                  req_live;

    // lookups own the index, refills use it when no lookup is present
    assign ram_addr = req ? vaddr : refill_vaddr;
    assign ram_idx  = ram_addr[vpn_base + bank_width +: idx_width];

    tlb_page_ram #(
        .TAG_WIDTH(tag_width),
        .DEPTH    (DEPTH),
        .BANK     (BANK)
    ) u_page_ram (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (req),
        .we        (refill_we),
        .idx       (ram_idx),
        .wtag      (refill_vaddr[pte_format_pkg::vaddr_width-1:tag_base]),
        .wdata     (refill_data),
        .tag_valid (ram_tag_valid),
        .tag       (ram_tag),
        .rdata     (ram_line),
        .sweep_busy(sweep_busy)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_live <= 1'b0;
        end else begin
            req_live <= req & ~flush;
        end
    end

    always_ff @(posedge clk) begin
        req_tag    <= vaddr[pte_format_pkg::vaddr_width-1:tag_base];
        req_offset <= vaddr[vpn_base +: bank_width];
    end

    assign hit   = req_live & ram_tag_valid & (ram_tag == req_tag);
    assign entry = ram_line[req_offset];

    a_refill_idle: assert property (
        @(posedge clk) disable iff (!rst_n) refill_we |-> !req
    );

endmodule

/* logic/pte_fault_check.sv */
module pte_fault_check #(
    parameter int LEVEL = 0
) (
    input  pte_format_pkg::pte_t           entry,
    input  tlb_access_pkg::access_source_t source,
    input  tlb_access_pkg::priv_mode_t     mode,
    input  logic                           sum,
    input  logic                           mxr,
    output logic                           fault
);

    pte_format_pkg::pte_flags_t flags;
    logic is_fetch;
    logic is_load;
    logic is_store;
    logic leaf;
    logic allowed;
    logic priv_bad;
    logic misaligned;

    assign flags    = entry.leaf.flags;
    assign is_fetch = source == tlb_access_pkg::source_fetch;
    assign is_load  = source == tlb_access_pkg::source_load;
    assign is_store = source == tlb_access_pkg::source_store;
    assign leaf     = flags.r | flags.w | flags.x;

    // mxr lets loads read execute-only pages
    assign allowed = (flags.r & is_load)
                   | (flags.x & (is_fetch | (is_load & mxr)))
                   | (flags.w & is_store);

    assign priv_bad = ((mode == tlb_access_pkg::mode_supervisor) & ~sum & flags.u)
                    | ((mode == tlb_access_pkg::mode_user) & ~flags.u);

    generate
        if (LEVEL == 1) begin : g_megapage
            // megapage must sit on a 4 MiB boundary
            assign misaligned = |entry.leaf.ppn0;
        end else begin : g_page
            assign misaligned = 1'b0;
        end
    endgenerate

    assign fault = ~flags.v
                 | (flags.w & ~flags.r)
                 | (|entry.leaf.rsw)
                 | (leaf & (~allowed | priv_bad | ~flags.a | (is_store & ~flags.d)))
                 | (leaf & misaligned);

endmodule

/* logic/pte_addr_gen.sv */
module pte_addr_gen #(
    parameter int LEVEL = 0
) (
    input  pte_format_pkg::pte_t                   entry,
    input  logic [pte_format_pkg::vaddr_width-1:0] vaddr,
    output logic [pte_format_pkg::paddr_width-1:0] paddr
);

    localparam int off_width = pte_format_pkg::page_offset_width;

    generate
        if (LEVEL == 0) begin : g_page
            assign paddr = {entry.ptr.ppn, vaddr[off_width-1:0]};
        end else begin : g_megapage
            logic leaf;
            logic [pte_format_pkg::vpn_width-1:0] vpn0;

            assign leaf = entry.leaf.flags.r | entry.leaf.flags.w | entry.leaf.flags.x;
            assign vpn0 = vaddr[off_width +: pte_format_pkg::vpn_width];

            // a pointer gives the address of the level-0 PTE for the walker
            assign paddr = leaf ? {entry.leaf.ppn1, vpn0, vaddr[off_width-1:0]}
                                : {entry.ptr.ppn, vpn0, 2'b00};
        end
    endgenerate

endmodule

/* logic/pte_cache.sv */
module pte_cache #(
    parameter int L0_BANK  = 4,
    parameter int L0_DEPTH = 16,
    parameter int L1_BANK  = 4,
    parameter int L1_DEPTH = 8
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   req,
    input  logic [pte_format_pkg::vaddr_width-1:0] vaddr,
    input  tlb_access_pkg::access_source_t         source,
    input  logic                                   flush,
    input  tlb_access_pkg::priv_mode_t             mode,
    input  logic                                   sum,
    input  logic                                   mxr,
    input  logic                                   refill_req,
    input  logic [1:0]                             refill_level,
    input  logic [pte_format_pkg::vaddr_width-1:0] refill_vaddr,
    input  logic [(L0_BANK > L1_BANK ? L0_BANK : L1_BANK)-1:0]
                 [pte_format_pkg::pte_width-1:0]   refill_data,
    output logic                                   refill_ready,
    input  logic                                   walk_full,
    output logic                                   hit,
    output logic                                   exception,
    output logic                                   error,
    output pte_format_pkg::pte_t                   hit_entry,
    output logic [pte_format_pkg::paddr_width-1:0] hit_paddr,
    output logic                                   hit_level,
    output tlb_access_pkg::access_source_t         source_o,
    output logic                                   walk_req,
    output logic [pte_format_pkg::vaddr_width-1:0] walk_vaddr,
    output tlb_access_pkg::access_source_t         walk_source,
    output logic [1:0]                             walk_valid,
    output logic [pte_format_pkg::paddr_width-1:0] walk_paddr_l0,
    output logic [pte_format_pkg::paddr_width-1:0] walk_paddr_l1
);

    logic                                   buf_req;
    logic [pte_format_pkg::vaddr_width-1:0] buf_vaddr;
    tlb_access_pkg::access_source_t         buf_source;

    logic [1:0] refill_we;
    logic [1:0] sweep_busy;
    logic [1:0] level_hit;
    logic [1:0] leaf;
    logic [1:0] fault;
    logic [1:0] first_hit;
    logic       resolved;

    pte_format_pkg::pte_t                   entry_l0;
    pte_format_pkg::pte_t                   entry_l1;
    logic [pte_format_pkg::paddr_width-1:0] paddr_l0;
    logic [pte_format_pkg::paddr_width-1:0] paddr_l1;

    // refills wait for the valid sweep and for a cycle without a lookup
    assign refill_ready = ~req & ~(|sweep_busy);
    assign refill_we    = refill_level & {2{refill_req & refill_ready}};

    // a flush at issue drops the request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            buf_req <= 1'b0;
        end else begin
            buf_req <= req & ~flush;
        end
    end

    always_ff @(posedge clk) begin
        buf_vaddr  <= vaddr;
        buf_source <= source;
    end

    tlb_page_level #(
        .LEVEL(0),
        .BANK (L0_BANK),
        .DEPTH(L0_DEPTH)
    ) u_level0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .flush       (flush),
        .vaddr       (vaddr),
        .refill_we   (refill_we[0]),
        .refill_vaddr(refill_vaddr),
        .refill_data (refill_data[L0_BANK-1:0]),
        .hit         (level_hit[0]),
        .entry       (entry_l0),
        .sweep_busy  (sweep_busy[0])
    );

    tlb_page_level #(
        .LEVEL(1),
        .BANK (L1_BANK),
        .DEPTH(L1_DEPTH)
    ) u_level1 (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .flush       (flush),
        .vaddr       (vaddr),
        .refill_we   (refill_we[1]),
        .refill_vaddr(refill_vaddr),
        .refill_data (refill_data[L1_BANK-1:0]),
        .hit         (level_hit[1]),
        .entry       (entry_l1),
        .sweep_busy  (sweep_busy[1])
    );

    pte_fault_check #(.LEVEL(0)) u_fault_l0 (
        .entry (entry_l0),
        .source(buf_source),
        .mode  (mode),
        .sum   (sum),
        .mxr   (mxr),
        .fault (fault[0])
    );

    pte_fault_check #(.LEVEL(1)) u_fault_l1 (
        .entry (entry_l1),
        .source(buf_source),
        .mode  (mode),
        .sum   (sum),
        .mxr   (mxr),
        .fault (fault[1])
    );

    pte_addr_gen #(.LEVEL(0)) u_addr_l0 (
        .entry(entry_l0),
        .vaddr(buf_vaddr),
        .paddr(paddr_l0)
    );

    pte_addr_gen #(.LEVEL(1)) u_addr_l1 (
        .entry(entry_l1),
        .vaddr(buf_vaddr),
        .paddr(paddr_l1)
    );

    assign leaf[0] = entry_l0.leaf.flags.r | entry_l0.leaf.flags.w | entry_l0.leaf.flags.x;
    assign leaf[1] = entry_l1.leaf.flags.r | entry_l1.leaf.flags.w | entry_l1.leaf.flags.x;

    // level 0 wins when both levels hit
    assign first_hit = {~level_hit[0] & level_hit[1], level_hit[0]};
    assign resolved  = |(first_hit & (leaf | fault));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hit       <= 1'b0;
            exception <= 1'b0;
            error     <= 1'b0;
            walk_req  <= 1'b0;
        end else begin
            hit       <= buf_req & (resolved | walk_full) & ~flush;
            exception <= |(first_hit & fault);
            // a full walker turns the miss into an error hit
            error     <= buf_req & ~resolved & walk_full & ~flush;
            walk_req  <= buf_req & ~resolved & ~walk_full & ~flush;
        end
    end

    always_ff @(posedge clk) begin
        hit_entry     <= first_hit[0] ? entry_l0 : entry_l1;
        hit_paddr     <= first_hit[0] ? paddr_l0 : paddr_l1;
        hit_level     <= first_hit[1];
        source_o      <= buf_source;
        walk_vaddr    <= buf_vaddr;
        walk_source   <= buf_source;
        walk_valid    <= level_hit;
        walk_paddr_l0 <= paddr_l0;
        walk_paddr_l1 <= paddr_l1;
    end

    // the walker refills one level at a time
    a_refill_onehot: assert property (
        @(posedge clk) disable iff (!rst_n) refill_req |-> $onehot(refill_level)
    );

endmodule

/* verification/pte_cache_tb.sv */
module pte_cache_tb;

    typedef struct packed {
        logic        hit;
        logic        exception;
        logic        error;
        logic        walk_req;
        logic        hit_level;
        logic [1:0]  walk_valid;
        logic [1:0]  source;
        logic [31:0] vaddr;
        logic [31:0] hit_entry;
        logic [33:0] hit_paddr;
        logic [33:0] walk_paddr_l0;
        logic [33:0] walk_paddr_l1;
    } expect_t;

    localparam int request_count = 80;
    localparam int refill_count  = 16;
    localparam int timeout       = (request_count * 4 + refill_count * 2 + 4 + 64) * 4;

    logic clk = 1'b0;
    logic rst_n;
    logic req;
    logic [31:0] vaddr;
    tlb_access_pkg::access_source_t source;
    logic flush;
    tlb_access_pkg::priv_mode_t mode;
    logic sum;
    logic mxr;
    logic refill_req;
    logic [1:0] refill_level;
    logic [31:0] refill_vaddr;
    logic [3:0][31:0] refill_data;
    logic refill_ready;
    logic walk_full;
    logic hit;
    logic exception;
    logic error;
    pte_format_pkg::pte_t hit_entry;
    logic [33:0] hit_paddr;
    logic hit_level;
    tlb_access_pkg::access_source_t source_o;
    logic walk_req;
    logic [31:0] walk_vaddr;
    tlb_access_pkg::access_source_t walk_source;
    logic [1:0] walk_valid;
    logic [33:0] walk_paddr_l0;
    logic [33:0] walk_paddr_l1;

    // software copy of both levels
    logic        l0_valid [16];
    logic [13:0] l0_tag   [16];
    logic [31:0] l0_line  [16][4];
    logic        l1_valid [8];
    logic [4:0]  l1_tag   [8];
    logic [31:0] l1_line  [8][4];

    logic [15:0] lfsr_state = 16'd44430;
    int          cycle_count = 0;
    logic        sweep_done = 1'b0;
    string       test_name = "reset";
    expect_t     exp_q [$];
    int          due_q [$];
    string       name_q [$];
    logic [31:0] bases [4];

    pte_cache u_pte_cache (.*);

    always #2 clk = ~clk;

    always @(posedge clk) cycle_count <= cycle_count + 1;

    // taps 16 14 13 11
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr_state[15]};
            lfsr_state = {lfsr_state[14:0],
                          lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
        end
        return value;
    endfunction

    function automatic logic pte_faults(input int level, input logic [31:0] pte,
                                        input logic [1:0] src, input logic [1:0] md,
                                        input logic s, input logic m);
        logic leaf;
        logic ok;
        logic priv;
        leaf = pte[1] | pte[2] | pte[3];
        ok   = (src == 2'b01) ? (pte[1] | (pte[3] & m)) : (src == 2'b10) ? pte[2] : pte[3];
        priv = (md == 2'b01 && pte[4] && !s) || (md == 2'b00 && !pte[4]);
        return !pte[0] || (pte[2] && !pte[1]) || (pte[9:8] != 0)
            || (leaf && (!ok || priv || !pte[6] || (src == 2'b10 && !pte[7])))
            || (level == 1 && leaf && pte[19:10] != 0);
    endfunction

    function automatic expect_t expected_result(input logic [31:0] va, input logic [1:0] src,
                                                input logic live);
        expect_t r;
        logic h0, h1, f0, f1, leaf0, leaf1, resolved;
        logic [31:0] e0, e1;
        logic [33:0] p0, p1;
        h0 = live && l0_valid[va[17:14]] && l0_tag[va[17:14]] == va[31:18];
        h1 = live && l1_valid[va[26:24]] && l1_tag[va[26:24]] == va[31:27];
        e0 = l0_line[va[17:14]][va[13:12]];
        e1 = l1_line[va[26:24]][va[23:22]];
        f0 = pte_faults(0, e0, src, mode, sum, mxr);
        f1 = pte_faults(1, e1, src, mode, sum, mxr);
        leaf0 = e0[1] | e0[2] | e0[3];
        leaf1 = e1[1] | e1[2] | e1[3];
        p0 = {e0[31:10], va[11:0]};
        p1 = leaf1 ? {e1[31:20], va[21:12], va[11:0]} : {e1[31:10], va[21:12], 2'b00};
        resolved = h0 ? (leaf0 | f0) : h1 ? (leaf1 | f1) : 1'b0;
        r.hit = live && (resolved || walk_full);
        r.exception = h0 ? f0 : h1 ? f1 : 1'b0;
        r.error = live && !resolved && walk_full;
        r.walk_req = live && !resolved && !walk_full;
        r.hit_level = !h0 && h1;
        r.walk_valid = {h1, h0};
        r.source = src;
        r.vaddr = va;
        r.hit_entry = h0 ? e0 : e1;
        r.hit_paddr = h0 ? p0 : p1;
        r.walk_paddr_l0 = p0;
        r.walk_paddr_l1 = p1;
        return r;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    // outputs settle well before the next rising edge
    always begin
        expect_t e;
        string n;
        @(posedge clk);
        #3;
        if (sweep_done) begin
            check_value({test_name, " refill_ready"}, !req, refill_ready);
        end
        if (due_q.size() > 0 && due_q[0] == cycle_count) begin
            e = exp_q.pop_front();
            n = name_q.pop_front();
            void'(due_q.pop_front());
            check_value({n, " hit"}, e.hit, hit);
            check_value({n, " exception"}, e.exception, exception);
            check_value({n, " error"}, e.error, error);
            check_value({n, " walk_req"}, e.walk_req, walk_req);
            check_value({n, " walk_valid"}, e.walk_valid, walk_valid);
            check_value({n, " walk_vaddr"}, e.vaddr, walk_vaddr);
            check_value({n, " source_o"}, e.source, source_o);
            check_value({n, " walk_source"}, e.source, walk_source);
            if (e.hit && e.walk_valid != 0) begin
                check_value({n, " hit_level"}, e.hit_level, hit_level);
                check_value({n, " hit_entry"}, e.hit_entry, hit_entry);
                check_value({n, " hit_paddr"}, e.hit_paddr, hit_paddr);
            end
            if (e.walk_req && e.walk_valid[0]) begin
                check_value({n, " walk_paddr_l0"}, e.walk_paddr_l0, walk_paddr_l0);
            end
            if (e.walk_req && e.walk_valid[1]) begin
                check_value({n, " walk_paddr_l1"}, e.walk_paddr_l1, walk_paddr_l1);
            end
        end
    end

    initial begin
        #(timeout);
        $display("timeout: the cache did not finish the tests in the expected time");
        $display("tests failed");
        $fatal(1);
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // CSR levels must hold through the cycle after issue
    task automatic issue_lookup(input logic [31:0] va, input logic [1:0] src,
                                input logic do_flush);
        req = 1'b1;
        vaddr = va;
        source = tlb_access_pkg::access_source_t'(src);
        flush = do_flush;
        exp_q.push_back(expected_result(va, src, !do_flush));
        due_q.push_back(cycle_count + 2);
        name_q.push_back(test_name);
        next_cycle();
    endtask

    task automatic drain();
        req = 1'b0;
        flush = 1'b0;
        refill_req = 1'b0;
        repeat (3) next_cycle();
    endtask

    task automatic refill_line(input int level, input logic [31:0] va,
                               input logic [3:0][31:0] data);
        req = 1'b0;
        refill_req = 1'b1;
        refill_level = (level == 0) ? 2'b01 : 2'b10;
        refill_vaddr = va;
        refill_data = data;
        for (int b = 0; b < 4; b++) begin
            if (level == 0) begin
                l0_line[va[17:14]][b] = data[b];
            end else begin
                l1_line[va[26:24]][b] = data[b];
            end
        end
        if (level == 0) begin
            l0_valid[va[17:14]] = 1'b1;
            l0_tag[va[17:14]] = va[31:18];
        end else begin
            l1_valid[va[26:24]] = 1'b1;
            l1_tag[va[26:24]] = va[31:27];
        end
        next_cycle();
        refill_req = 1'b0;
    endtask

    function automatic logic [1:0] random_source();
        logic [1:0] s;
        s = 2'(random_bits(2));
        return (s == 2'b11) ? 2'b01 : s;
    endfunction

    initial begin
        logic [3:0][31:0] line;
        logic [1:0] md;
        logic [31:0] va;
        for (int i = 0; i < 16; i++) begin
            l0_valid[i] = 1'b0;
            l0_tag[i] = '0;
            for (int b = 0; b < 4; b++) l0_line[i][b] = '0;
        end
        for (int i = 0; i < 8; i++) begin
            l1_valid[i] = 1'b0;
            l1_tag[i] = '0;
            for (int b = 0; b < 4; b++) l1_line[i][b] = '0;
        end
        rst_n = 1'b0;
        req = 1'b0;
        vaddr = '0;
        source = tlb_access_pkg::source_fetch;
        flush = 1'b0;
        mode = tlb_access_pkg::mode_user;
        sum = 1'b0;
        mxr = 1'b0;
        refill_req = 1'b0;
        refill_level = '0;
        refill_vaddr = '0;
        refill_data = '0;
        walk_full = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        while (!refill_ready) next_cycle();
        sweep_done = 1'b1;

        test_name = "empty_cache";
        for (int i = 0; i < 8; i++) begin
            issue_lookup({1'b0, 31'(random_bits(31))}, random_source(), 1'b0);
        end
        drain();
        walk_full = 1'b1;
        for (int i = 0; i < 8; i++) begin
            issue_lookup({1'b0, 31'(random_bits(31))}, random_source(), 1'b0);
        end
        drain();
        walk_full = 1'b0;

        test_name = "level0_leaf";
        for (int i = 0; i < 4; i++) begin
            bases[i] = {1'b0, 31'(random_bits(31))};
            for (int b = 0; b < 4; b++) line[b] = {22'(random_bits(22)), 2'b00, 8'hdf};
            refill_line(0, bases[i], line);
        end
        for (int i = 0; i < 16; i++) begin
            issue_lookup({bases[i % 4][31:14], 14'(random_bits(14))}, random_source(), 1'b0);
        end
        drain();

        test_name = "level1_megapage";
        for (int b = 0; b < 4; b++) begin
            line[b] = {12'(random_bits(12)),
                       (b % 2 == 0) ? 10'd0 : 10'(random_bits(10)),
                       2'b00, 8'hdf};
        end
        refill_line(1, bases[0], line);
        for (int i = 0; i < 8; i++) begin
            va = (i % 4 == 0) ? bases[0] : {bases[0][31:24], 24'(random_bits(24))};
            issue_lookup(va, random_source(), 1'b0);
        end
        drain();

        test_name = "random_permissions";
        for (int i = 0; i < 2; i++) begin
            for (int b = 0; b < 4; b++) line[b] = random_bits(32);
            refill_line(0, bases[i], line);
        end
        for (int i = 0; i < 24; i++) begin
            md = 2'(random_bits(2));
            mode = tlb_access_pkg::priv_mode_t'((md == 2'b10) ? 2'b11 : md);
            sum = 1'(random_bits(1));
            mxr = 1'(random_bits(1));
            issue_lookup({bases[i % 2][31:14], 14'(random_bits(14))}, random_source(), 1'b0);
            req = 1'b0;
            next_cycle();
        end
        drain();
        mode = tlb_access_pkg::mode_user;

        test_name = "level1_pointer";
        va = {1'b1, 31'(random_bits(31))};
        for (int b = 0; b < 4; b++) line[b] = {22'(random_bits(22)), 2'b00, 8'h01};
        refill_line(1, va, line);
        issue_lookup(va, random_source(), 1'b0);
        drain();
        // lookup and refill in the same cycle, the refill must be lost
        refill_req = 1'b1;
        refill_level = 2'b01;
        refill_vaddr = va;
        for (int b = 0; b < 4; b++) refill_data[b] = {22'(random_bits(22)), 2'b00, 8'hdf};
        issue_lookup(va, random_source(), 1'b0);
        refill_req = 1'b0;
        drain();
        issue_lookup(va, random_source(), 1'b0);
        drain();

        test_name = "flush";
        issue_lookup(bases[2], random_source(), 1'b1);
        issue_lookup(bases[2], random_source(), 1'b0);
        req = 1'b0;
        next_cycle();
        issue_lookup(bases[3], random_source(), 1'b1);
        issue_lookup(bases[3], random_source(), 1'b0);
        drain();

        if (exp_q.size() == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("some expected results were never compared");
            $display("tests failed");
            $fatal(1);
        end
    end

endmodule

/* pte_cache.f */
logic/pte_format_pkg.sv
logic/tlb_access_pkg.sv
logic/tlb_page_ram.sv
logic/tlb_page_level.sv
logic/pte_fault_check.sv
logic/pte_addr_gen.sv
logic/pte_cache.sv
verification/pte_cache_tb.sv
